//--- design/l1dc_macros.svh
`ifndef L1DC_MACROS_SVH
`define L1DC_MACROS_SVH

// Word address width, CPU and L2 side
`define L1DC_ADDR_W 16

// Data word width
`define L1DC_DATA_W 32

// Set index width, 64 sets
`define L1DC_IDX_W 6

// Write-back buffer entries
`define L1DC_WBB_DEPTH 4

`endif

//--- design/l1dc_pkg.sv
`include "l1dc_macros.svh"

package l1dc_pkg;

  // Wishbone classic request, held by the master until ack
  typedef struct packed {
    logic                    cyc;
    logic                    stb;
    logic                    we;
    logic [`L1DC_ADDR_W-1:0] adr;
    logic [`L1DC_DATA_W-1:0] dat;
  } wb_req_t;

  // Wishbone classic response
  typedef struct packed {
    logic                    ack;
    logic [`L1DC_DATA_W-1:0] dat;
  } wb_rsp_t;

  // Sweeper request, one set at a time
  typedef struct packed {
    logic                   valid;
    logic [`L1DC_IDX_W-1:0] idx;
  } sweep_req_t;

  // One queued write-back toward L2
  typedef struct packed {
    logic [`L1DC_ADDR_W-1:0] adr;
    logic [`L1DC_DATA_W-1:0] dat;
  } wbb_entry_t;

endpackage

//--- design/l1dc_sync_ctrl.sv
`include "l1dc_macros.svh"

module l1dc_sync_ctrl #(
  parameter int IDX_W = `L1DC_IDX_W
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Start pulse from the CSR block
  input  logic                 sync_i,
  // Array has handled the current index
  input  logic                 advance_i,
  input  logic                 wbb_empty_i,
  output l1dc_pkg::sweep_req_t sweep_req_o,
  // One-cycle completion pulse
  output logic                 done_o
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_SWEEP,
    S_WAIT_BUF,
    S_DONE
  } state_e;

  state_e           state_q;
  state_e           state_d;
  logic [IDX_W-1:0] cnt_q;
  logic             last_idx;

  // Counter wraps back to zero after the last set
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (advance_i && state_q == S_SWEEP) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign last_idx = &cnt_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        if (sync_i) begin
          state_d = S_SWEEP;
        end
      end
      // Last set handled, only the buffer is left
      S_SWEEP: begin
        if (last_idx && advance_i) begin
          state_d = S_WAIT_BUF;
        end
      end
      // Dirty lines still on their way to L2
      S_WAIT_BUF: begin
        if (wbb_empty_i) begin
          state_d = S_DONE;
        end
      end
      S_DONE: begin
        state_d = S_IDLE;
      end
      default: begin
        state_d = S_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign sweep_req_o.valid = (state_q == S_SWEEP);
  assign sweep_req_o.idx   = cnt_q;
  assign done_o            = (state_q == S_DONE);

  // Array must only answer an index that is being presented
  advance_in_sweep_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni) advance_i |-> sweep_req_o.valid
  );

endmodule

//--- design/l1dc_array.sv
`include "l1dc_macros.svh"

module l1dc_array (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // CPU slave port
  input  l1dc_pkg::wb_req_t       cpu_req_i,
  output l1dc_pkg::wb_rsp_t       cpu_rsp_o,
  // Sweeper
  input  l1dc_pkg::sweep_req_t    sweep_req_i,
  output logic                    advance_o,
  // Sync in progress
  input  logic                    busy_i,
  // Write-back buffer
  output logic                    wbb_push_o,
  output l1dc_pkg::wbb_entry_t    wbb_entry_o,
  input  logic                    wbb_full_i,
  input  logic                    wbb_empty_i,
  // Refill through the L2 port
  output logic                    refill_req_o,
  output logic [`L1DC_ADDR_W-1:0] refill_adr_o,
  input  logic                    refill_ack_i,
  input  logic [`L1DC_DATA_W-1:0] refill_dat_i
);

  localparam int ADDR_W = `L1DC_ADDR_W;
  localparam int DATA_W = `L1DC_DATA_W;
  localparam int IDX_W  = `L1DC_IDX_W;
  localparam int TAG_W  = ADDR_W - IDX_W;
  localparam int SETS   = 1 << IDX_W;

  typedef enum logic [2:0] {
    S_LOOKUP,
    S_EVICT,
    S_DRAIN,
    S_REFILL,
    S_RESPOND
  } state_e;

  state_e            state_q;
  state_e            state_d;

  // Line storage
  logic [TAG_W-1:0]  tag_q  [SETS];
  logic [DATA_W-1:0] data_q [SETS];
  logic [SETS-1:0]   valid_q;
  logic [SETS-1:0]   dirty_q;

  logic [IDX_W-1:0]  cpu_idx;
  logic [TAG_W-1:0]  cpu_tag;
  logic [IDX_W-1:0]  line_idx;
  logic              cpu_stb;
  logic              sweep_on;
  logic              hit;
  logic              line_dirty;
  logic              cpu_ack;
  logic              data_we;
  logic [DATA_W-1:0] data_wdat;
  logic              tag_we;
  logic              valid_set;
  logic              valid_clr;
  logic              dirty_set;
  logic              dirty_clr;

  assign cpu_idx  = cpu_req_i.adr[IDX_W-1:0];
  assign cpu_tag  = cpu_req_i.adr[ADDR_W-1:IDX_W];
  assign cpu_stb  = cpu_req_i.cyc && cpu_req_i.stb;

  // Sweep owns the set lookup whenever it is active in lookup
  assign sweep_on = (state_q == S_LOOKUP) && sweep_req_i.valid;
  assign line_idx = sweep_on ? sweep_req_i.idx : cpu_idx;

  assign hit        = valid_q[cpu_idx] && (tag_q[cpu_idx] == cpu_tag);
  assign line_dirty = valid_q[line_idx] && dirty_q[line_idx];

  // Victim or swept line with its address rebuilt from the stored tag
  assign wbb_entry_o.adr = {tag_q[line_idx], line_idx};
  assign wbb_entry_o.dat = data_q[line_idx];

  assign refill_adr_o = cpu_req_i.adr;

  always_comb begin
    state_d      = state_q;
    advance_o    = 1'b0;
    wbb_push_o   = 1'b0;
    refill_req_o = 1'b0;
    cpu_ack      = 1'b0;
    data_we      = 1'b0;
    data_wdat    = cpu_req_i.dat;
    tag_we       = 1'b0;
    valid_set    = 1'b0;
    valid_clr    = 1'b0;
    dirty_set    = 1'b0;
    dirty_clr    = 1'b0;
    case (state_q)
      S_LOOKUP: begin
        if (sweep_on) begin
          // Clean lines pass at once while dirty ones need a free slot
          if (!line_dirty) begin
            advance_o = 1'b1;
          end else if (!wbb_full_i) begin
            wbb_push_o = 1'b1;
            dirty_clr  = 1'b1;
            advance_o  = 1'b1;
          end
        end else if (cpu_stb && !busy_i) begin
          if (hit) begin
            // Write hit merges now and acks next cycle
            data_we   = cpu_req_i.we;
            dirty_set = cpu_req_i.we;
            state_d   = S_RESPOND;
          end else if (line_dirty) begin
            state_d = S_EVICT;
          end else begin
            state_d = S_DRAIN;
          end
        end
      end
      S_EVICT: begin
        if (!wbb_full_i) begin
          wbb_push_o = 1'b1;
          valid_clr  = 1'b1;
          dirty_clr  = 1'b1;
          state_d    = S_DRAIN;
        end
      end
      // No forwarding from the buffer so L2 must be current first
      S_DRAIN: begin
        if (wbb_empty_i) begin
          state_d = S_REFILL;
        end
      end
      // Fill the line and look it up again as a hit
      S_REFILL: begin
        refill_req_o = 1'b1;
        if (refill_ack_i) begin
          data_we   = 1'b1;
          data_wdat = refill_dat_i;
          tag_we    = 1'b1;
          valid_set = 1'b1;
          dirty_clr = 1'b1;
          state_d   = S_LOOKUP;
        end
      end
      S_RESPOND: begin
        // Retry after a sync that started meanwhile
        cpu_ack = !busy_i && !sweep_req_i.valid;
        state_d = S_LOOKUP;
      end
      default: begin
        state_d = S_LOOKUP;
      end
    endcase
  end

  assign cpu_rsp_o.ack = cpu_ack;
  assign cpu_rsp_o.dat = data_q[line_idx];

  always_ff @(posedge clk_i) begin
    if (data_we) begin
      data_q[line_idx] <= data_wdat;
    end
    if (tag_we) begin
      tag_q[line_idx] <= cpu_tag;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= S_LOOKUP;
      valid_q <= '0;
      dirty_q <= '0;
    end else begin
      state_q <= state_d;
      if (valid_set) begin
        valid_q[line_idx] <= 1'b1;
      end else if (valid_clr) begin
        valid_q[line_idx] <= 1'b0;
      end
      if (dirty_set) begin
        dirty_q[line_idx] <= 1'b1;
      end else if (dirty_clr) begin
        dirty_q[line_idx] <= 1'b0;
      end
    end
  end

  // Refill only with L2 up to date
  refill_after_drain_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni) refill_req_o |-> wbb_empty_i
  );

endmodule

//--- design/l1dc_wbb.sv
`include "l1dc_macros.svh"

module l1dc_wbb #(
  parameter type T     = l1dc_pkg::wbb_entry_t,
  parameter int  DEPTH = `L1DC_WBB_DEPTH
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic push_i,
  input  T     entry_i,
  input  logic pop_i,
  output T     head_o,
  output logic full_o,
  output logic empty_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  T                 mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  // Entry written at the tail
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= entry_i;
    end
  end

  // Pointers wrap at DEPTH for any depth
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop keep the count
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  assign head_o  = mem_q[rd_ptr_q];
  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);

  no_pop_empty_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni) pop_i |-> !empty_o
  );

  no_push_full_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni) push_i |-> !full_o
  );

endmodule

//--- design/l1dc_l2_port.sv
`include "l1dc_macros.svh"

module l1dc_l2_port (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Buffer head
  input  l1dc_pkg::wbb_entry_t    wbb_head_i,
  input  logic                    wbb_empty_i,
  output logic                    wbb_pop_o,
  // Refill from the array
  input  logic                    refill_req_i,
  input  logic [`L1DC_ADDR_W-1:0] refill_adr_i,
  output logic                    refill_ack_o,
  output logic [`L1DC_DATA_W-1:0] refill_dat_o,
  // Wishbone classic master toward L2
  output l1dc_pkg::wb_req_t       l2_req_o,
  input  l1dc_pkg::wb_rsp_t       l2_rsp_i
);

  import l1dc_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_WRITE,
    S_READ
  } state_e;

  state_e  state_q;
  state_e  state_d;
  wb_req_t req_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      // Draining first, refill only on an empty buffer
      S_IDLE: begin
        if (!wbb_empty_i) begin
          state_d = S_WRITE;
        end else if (refill_req_i) begin
          state_d = S_READ;
        end
      end
      S_WRITE, S_READ: begin
        if (l2_rsp_i.ack) begin
          state_d = S_IDLE;
        end
      end
      default: begin
        state_d = S_IDLE;
      end
    endcase
  end

  // Cycle fields latched at start, held until ack
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= S_IDLE;
      req_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == S_IDLE) begin
        req_q.cyc <= (state_d != S_IDLE);
        req_q.stb <= (state_d != S_IDLE);
        req_q.we  <= (state_d == S_WRITE);
        req_q.adr <= (state_d == S_WRITE) ? wbb_head_i.adr : refill_adr_i;
        req_q.dat <= wbb_head_i.dat;
      end else if (l2_rsp_i.ack) begin
        req_q.cyc <= 1'b0;
        req_q.stb <= 1'b0;
      end
    end
  end

  assign l2_req_o = req_q;

  // Ack turns into pop or refill completion
  assign wbb_pop_o    = (state_q == S_WRITE) && l2_rsp_i.ack;
  assign refill_ack_o = (state_q == S_READ) && l2_rsp_i.ack;
  assign refill_dat_o = l2_rsp_i.dat;

endmodule

//--- design/l1dc_csr.sv
`include "l1dc_macros.svh"

module l1dc_csr (
  input  logic              clk_i,
  input  logic              rst_ni,
  // Wishbone classic slave
  input  l1dc_pkg::wb_req_t csr_req_i,
  output l1dc_pkg::wb_rsp_t csr_rsp_o,
  // Sweeper control
  output logic              sync_o,
  input  logic              done_i,
  // Sync running, stalls the CPU port
  output logic              busy_o
);

  localparam int ADDR_W = `L1DC_ADDR_W;
  localparam int DATA_W = `L1DC_DATA_W;

  // Register map
  localparam logic [ADDR_W-1:0] ADR_CTRL   = ADDR_W'(0);
  localparam logic [ADDR_W-1:0] ADR_STATUS = ADDR_W'(1);

  logic ack_q;
  logic sync_q;
  logic busy_q;
  logic done_q;
  logic access;
  logic sync_wr;

  // One ack per request, stb still high during the ack cycle
  assign access  = csr_req_i.cyc && csr_req_i.stb && !ack_q;

  // Start ignored while a sweep runs
  assign sync_wr = access && csr_req_i.we && (csr_req_i.adr == ADR_CTRL) &&
                   csr_req_i.dat[0] && !busy_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q  <= 1'b0;
      sync_q <= 1'b0;
      busy_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      ack_q  <= access;
      sync_q <= sync_wr;
      // Busy and sticky done swap on start and completion
      if (sync_wr) begin
        busy_q <= 1'b1;
        done_q <= 1'b0;
      end else if (done_i) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
    end
  end

  assign sync_o = sync_q;
  assign busy_o = busy_q;

  // STATUS is bit 1 done, bit 0 busy; CTRL reads zero
  assign csr_rsp_o.ack = ack_q;
  assign csr_rsp_o.dat = (csr_req_i.adr == ADR_STATUS) ?
                         {{(DATA_W - 2){1'b0}}, done_q, busy_q} : '0;

  // Sweeper completes only a sweep started from here
  done_while_busy_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni) done_i |-> busy_q
  );

endmodule

//--- design/l1dc_top.sv
`include "l1dc_macros.svh"

module l1dc_top (
  input  logic              clk_i,
  input  logic              rst_ni,
  // CPU data port
  input  l1dc_pkg::wb_req_t cpu_req_i,
  output l1dc_pkg::wb_rsp_t cpu_rsp_o,
  // Control and status
  input  l1dc_pkg::wb_req_t csr_req_i,
  output l1dc_pkg::wb_rsp_t csr_rsp_o,
  // Toward L2
  output l1dc_pkg::wb_req_t l2_req_o,
  input  l1dc_pkg::wb_rsp_t l2_rsp_i
);

  import l1dc_pkg::*;

  logic                    sync;
  logic                    done;
  logic                    busy;
  sweep_req_t              sweep_req;
  logic                    advance;
  logic                    wbb_push;
  wbb_entry_t              wbb_entry;
  wbb_entry_t              wbb_head;
  logic                    wbb_pop;
  logic                    wbb_full;
  logic                    wbb_empty;
  logic                    refill_req;
  logic [`L1DC_ADDR_W-1:0] refill_adr;
  logic                    refill_ack;
  logic [`L1DC_DATA_W-1:0] refill_dat;

  l1dc_csr l1dc_csr_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .csr_req_i (csr_req_i),
    .csr_rsp_o (csr_rsp_o),
    .sync_o    (sync),
    .done_i    (done),
    .busy_o    (busy)
  );

  l1dc_sync_ctrl #(
    .IDX_W (`L1DC_IDX_W)
  ) l1dc_sync_ctrl_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .sync_i      (sync),
    .advance_i   (advance),
    .wbb_empty_i (wbb_empty),
    .sweep_req_o (sweep_req),
    .done_o      (done)
  );

  l1dc_array l1dc_array_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cpu_req_i    (cpu_req_i),
    .cpu_rsp_o    (cpu_rsp_o),
    .sweep_req_i  (sweep_req),
    .advance_o    (advance),
    .busy_i       (busy),
    .wbb_push_o   (wbb_push),
    .wbb_entry_o  (wbb_entry),
    .wbb_full_i   (wbb_full),
    .wbb_empty_i  (wbb_empty),
    .refill_req_o (refill_req),
    .refill_adr_o (refill_adr),
    .refill_ack_i (refill_ack),
    .refill_dat_i (refill_dat)
  );

  // Write-back FIFO of queued victims and swept lines
  l1dc_wbb #(
    .T     (wbb_entry_t),
    .DEPTH (`L1DC_WBB_DEPTH)
  ) l1dc_wbb_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (wbb_push),
    .entry_i (wbb_entry),
    .pop_i   (wbb_pop),
    .head_o  (wbb_head),
    .full_o  (wbb_full),
    .empty_o (wbb_empty)
  );

  l1dc_l2_port l1dc_l2_port_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .wbb_head_i   (wbb_head),
    .wbb_empty_i  (wbb_empty),
    .wbb_pop_o    (wbb_pop),
    .refill_req_i (refill_req),
    .refill_adr_i (refill_adr),
    .refill_ack_o (refill_ack),
    .refill_dat_o (refill_dat),
    .l2_req_o     (l2_req_o),
    .l2_rsp_i     (l2_rsp_i)
  );

endmodule

//--- bench/l2_mem_model.sv
`include "l1dc_macros.svh"

module l2_mem_model #(
  parameter logic [31:0] SEED      = 32'hfc7,
  parameter int          MAX_DELAY = 3
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  // Wishbone classic slave
  input  l1dc_pkg::wb_req_t req_i,
  output l1dc_pkg::wb_rsp_t rsp_o
);
  timeunit 1ns;
  timeprecision 1ps;

  import l1dc_pkg::*;

  localparam int ADDR_W = `L1DC_ADDR_W;
  localparam int DATA_W = `L1DC_DATA_W;

  logic [DATA_W-1:0] mem [1 << ADDR_W];
  logic [31:0]       rng_q;
  logic [3:0]        wait_q;
  logic              ack_q;
  logic [DATA_W-1:0] rdat_q;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Every word differs with the inverted address in the upper half
  function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] a);
    return DATA_W'({~a, a});
  endfunction

  // Backdoor read for the checker
  function logic [DATA_W-1:0] peek(input logic [ADDR_W-1:0] a);
    return mem[a];
  endfunction

  initial begin
    for (int a = 0; a < (1 << ADDR_W); a++) begin
      mem[a] = fill_word(ADDR_W'(a));
    end
  end

  // One ack pulse per request after a random number of wait cycles
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q  <= 1'b0;
      rdat_q <= '0;
      wait_q <= '0;
      rng_q  <= SEED;
    end else begin
      ack_q <= 1'b0;
      if (req_i.cyc && req_i.stb && !ack_q) begin
        if (wait_q == '0) begin
          ack_q  <= 1'b1;
          rdat_q <= mem[req_i.adr];
          if (req_i.we) begin
            mem[req_i.adr] <= req_i.dat;
          end
          // Delay for the next request
          rng_q  <= lcg_step(rng_q);
          wait_q <= 4'(rng_q[18:16] % (MAX_DELAY + 1));
        end else begin
          wait_q <= wait_q - 1'b1;
        end
      end
    end
  end

  assign rsp_o.ack = ack_q;
  assign rsp_o.dat = rdat_q;

endmodule

//--- bench/tb_l1dc.sv
`include "l1dc_macros.svh"

module tb_l1dc;
  timeunit 1ns;
  timeprecision 1ps;

  import l1dc_pkg::*;

  localparam int ADDR_W   = `L1DC_ADDR_W;
  localparam int DATA_W   = `L1DC_DATA_W;
  localparam int ACK_TMO  = 4000;
  localparam int POLL_TMO = 2000;
  localparam int IDLE_TMO = 1000;
  localparam int RAND_OPS = 300;

  logic    clk;
  logic    rst_n;
  wb_req_t cpu_req;
  wb_rsp_t cpu_rsp;
  wb_req_t csr_req;
  wb_rsp_t csr_rsp;
  wb_req_t l2_req;
  wb_rsp_t l2_rsp;

  // Last value written per address
  logic [DATA_W-1:0] shadow [1 << ADDR_W];
  bit                seen [1 << ADDR_W];
  logic [ADDR_W-1:0] written [$];

  logic [31:0]       rng;
  string             test_name;
  logic              in_reset;
  logic [DATA_W-1:0] exp_rd;
  logic              l2_chk;
  logic [DATA_W-1:0] l2_exp;
  logic [DATA_W-1:0] l2_act;
  logic [ADDR_W-1:0] a;
  logic [ADDR_W-1:0] b;

  l1dc_top l1dc_top_i (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .cpu_req_i (cpu_req),
    .cpu_rsp_o (cpu_rsp),
    .csr_req_i (csr_req),
    .csr_rsp_o (csr_rsp),
    .l2_req_o  (l2_req),
    .l2_rsp_i  (l2_rsp)
  );

  l2_mem_model #(
    .SEED (32'hfc7)
  ) l2_mem_i (
    .clk_i  (clk),
    .rst_ni (rst_n),
    .req_i  (l2_req),
    .rsp_o  (l2_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic fail_value(input string what, input logic [DATA_W-1:0] exp,
                            input logic [DATA_W-1:0] act);
    $display("error %s: expected %h actual %h", what, exp, act);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic fail_plain(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1);
  endtask

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // Request held until the ack seen on a falling edge
  task automatic cpu_access(input logic we, input logic [ADDR_W-1:0] adr,
                            input logic [DATA_W-1:0] dat);
    int n;
    n           = 0;
    cpu_req.cyc = 1'b1;
    cpu_req.stb = 1'b1;
    cpu_req.we  = we;
    cpu_req.adr = adr;
    cpu_req.dat = dat;
    @(negedge clk);
    while (!cpu_rsp.ack) begin
      n++;
      if (n > ACK_TMO) begin
        fail_plain("timeout waiting for CPU ack");
      end
      @(negedge clk);
    end
    next_cycle();
    cpu_req = '0;
  endtask

  task automatic csr_access(input logic we, input logic [ADDR_W-1:0] adr,
                            input logic [DATA_W-1:0] dat, output logic [DATA_W-1:0] rdat);
    int n;
    n           = 0;
    csr_req.cyc = 1'b1;
    csr_req.stb = 1'b1;
    csr_req.we  = we;
    csr_req.adr = adr;
    csr_req.dat = dat;
    @(negedge clk);
    while (!csr_rsp.ack) begin
      n++;
      if (n > ACK_TMO) begin
        fail_plain("timeout waiting for CSR ack");
      end
      @(negedge clk);
    end
    rdat = csr_rsp.dat;
    next_cycle();
    csr_req = '0;
  endtask

  task automatic cpu_write(input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] dat);
    if (!seen[adr]) begin
      seen[adr] = 1'b1;
      written.push_back(adr);
    end
    shadow[adr] = dat;
    cpu_access(1'b1, adr, dat);
  endtask

  // Read data is compared by rd_data_a
  task automatic cpu_read(input logic [ADDR_W-1:0] adr);
    exp_rd = shadow[adr];
    cpu_access(1'b0, adr, '0);
  endtask

  // Poll STATUS until busy 0 and done 1
  task automatic wait_sync_done();
    logic [DATA_W-1:0] st;
    int                n;
    n  = 0;
    st = '0;
    while (st[1:0] != 2'b10) begin
      n++;
      if (n > POLL_TMO) begin
        fail_plain("sync never reported done");
      end
      csr_access(1'b0, ADDR_W'(1), '0, st);
    end
  endtask

  task automatic run_sync();
    logic [DATA_W-1:0] st;
    csr_access(1'b1, ADDR_W'(0), DATA_W'(1), st);
    wait_sync_done();
  endtask

  // Buffer empty and no L2 cycle open
  task automatic wait_l2_idle();
    int n;
    n = 0;
    @(negedge clk);
    while (!(l1dc_top_i.wbb_empty && !l2_req.cyc)) begin
      n++;
      if (n > IDLE_TMO) begin
        fail_plain("L2 port never went idle");
      end
      @(negedge clk);
    end
    next_cycle();
  endtask

  // L2 word compared by l2_match_a on the next edge
  task automatic check_l2(input logic [ADDR_W-1:0] adr);
    l2_exp = shadow[adr];
    l2_act = l2_mem_i.peek(adr);
    l2_chk = 1'b1;
    next_cycle();
    l2_chk = 1'b0;
  endtask

  task automatic check_all_l2();
    foreach (written[i]) begin
      check_l2(written[i]);
    end
  endtask

  reset_quiet_a: assert property (
    @(posedge clk) in_reset |->
      !cpu_rsp.ack && !csr_rsp.ack && !l2_req.cyc && !l1dc_top_i.busy
  ) else fail_plain("bus activity or busy seen around reset");

  rd_data_a: assert property (
    @(posedge clk) disable iff (!rst_n)
      cpu_req.cyc && cpu_req.stb && !cpu_req.we && cpu_rsp.ack |-> cpu_rsp.dat == exp_rd
  ) else fail_value(test_name, $sampled(exp_rd), $sampled(cpu_rsp.dat));

  // CPU must stay stalled for the whole sync
  stall_a: assert property (
    @(posedge clk) disable iff (!rst_n) cpu_rsp.ack |-> !l1dc_top_i.busy
  ) else fail_plain("CPU request acked while sync busy");

  l2_match_a: assert property (
    @(posedge clk) disable iff (!rst_n) l2_chk |-> l2_act == l2_exp
  ) else fail_value(test_name, $sampled(l2_exp), $sampled(l2_act));

  initial begin
    cpu_req   = '0;
    csr_req   = '0;
    rst_n     = 1'b0;
    in_reset  = 1'b0;
    exp_rd    = '0;
    l2_chk    = 1'b0;
    l2_exp    = '0;
    l2_act    = '0;
    a         = '0;
    b         = '0;
    rng       = 32'hfc7;
    test_name = "reset";
    // Flops are defined once the first edge has seen reset low
    @(posedge clk);
    #1;
    in_reset = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // Outputs still quiet two cycles after release
    repeat (2) next_cycle();
    in_reset = 1'b0;

    // Immediate reads hit and later reads partly refill
    test_name = "read_after_write";
    for (int i = 0; i < 16; i++) begin
      rng = lcg_step(rng);
      a   = rng[31:16];
      rng = lcg_step(rng);
      cpu_write(a, rng);
      cpu_read(a);
    end
    foreach (written[i]) begin
      cpu_read(written[i]);
    end

    // Same set with different tags
    test_name = "eviction";
    a = 16'h0105;
    b = a ^ 16'h0400;
    rng = lcg_step(rng);
    cpu_write(a, rng);
    rng = lcg_step(rng);
    cpu_write(b, rng);
    cpu_read(a);
    wait_l2_idle();
    check_l2(a);
    check_l2(b);

    test_name = "sync";
    run_sync();
    check_all_l2();

    // Dirty line first so the sweep has work to do
    test_name = "stall_during_sync";
    rng = lcg_step(rng);
    a   = rng[31:16];
    rng = lcg_step(rng);
    cpu_write(a, rng);
    csr_access(1'b1, ADDR_W'(0), DATA_W'(1), l2_act);
    fork
      cpu_read(a);
      wait_sync_done();
    join
    check_l2(a);

    // 256 addresses over 64 sets give four tags per set
    test_name = "random_backpressure";
    for (int i = 0; i < RAND_OPS; i++) begin
      rng = lcg_step(rng);
      b   = {8'h00, rng[31:24]};
      if (written.size() == 0 || rng[20]) begin
        rng = lcg_step(rng);
        cpu_write(b, rng);
      end else begin
        cpu_read(written[rng[27:16] % written.size()]);
      end
    end
    run_sync();
    check_all_l2();

    $display("Test OK");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+design
design/l1dc_pkg.sv
design/l1dc_sync_ctrl.sv
design/l1dc_array.sv
design/l1dc_wbb.sv
design/l1dc_l2_port.sv
design/l1dc_csr.sv
design/l1dc_top.sv
bench/l2_mem_model.sv
bench/tb_l1dc.sv
